/* all.f */
rtl/dispatchPkg.sv
rtl/dispatchLane.sv
rtl/spaceCheck.sv
rtl/dispatchLatch.sv
rtl/dispatchTop.sv
test/dispatch_assert.sv
test/dispatchTb.sv

/* rtl/dispatchLane.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchLane (
  input  wire dispatchPkg::renamedPkt_t             renamedPkt_i,
  input  wire                                       ctrlVerified_i,
  input  wire [dispatchPkg::CHECKPOINTS_LOG-1:0]    ctrlVerifiedId_i,
  output dispatchPkg::issuePkt_t                    issuePkt_o,
  output dispatchPkg::alPkt_t                       alPkt_o,
  output dispatchPkg::lsqPkt_t                      lsqPkt_o,
  output dispatchPkg::branchMask_t                  branchMask_o
);

  dispatchPkg::branchMask_t clearMask;
  dispatchPkg::branchMask_t newMask;
  logic                     isLoad;
  logic                     isStore;

  // Branch resolved correctly, so nothing depends on its checkpoint any more
  always_comb begin
    clearMask = '0;
    if (ctrlVerified_i) begin
      clearMask[ctrlVerifiedId_i] = 1'b1;
    end
  end

  assign newMask      = renamedPkt_i.branchMask & ~clearMask;
  assign branchMask_o = newMask; // Also fed back to the rename latch

  assign isLoad  = (renamedPkt_i.instType == dispatchPkg::INST_LOAD);
  assign isStore = (renamedPkt_i.instType == dispatchPkg::INST_STORE);

  always_comb begin
    issuePkt_o.pc           = renamedPkt_i.pc;
    issuePkt_o.instType     = renamedPkt_i.instType;
    issuePkt_o.checkpointId = renamedPkt_i.checkpointId;
    issuePkt_o.branchMask   = newMask;
    issuePkt_o.physDest     = renamedPkt_i.physDest;
    issuePkt_o.physSrc1     = renamedPkt_i.physSrc1;
    issuePkt_o.physSrc2     = renamedPkt_i.physSrc2;
    issuePkt_o.isLoad       = isLoad;
    issuePkt_o.isStore      = isStore;
  end

  // Active list keeps what retirement and recovery need
  always_comb begin
    alPkt_o.isLoad      = isLoad;
    alPkt_o.isStore     = isStore;
    alPkt_o.pc          = renamedPkt_i.pc;
    alPkt_o.logDest     = renamedPkt_i.logDest;
    alPkt_o.physDest    = renamedPkt_i.physDest;
    alPkt_o.oldPhysDest = renamedPkt_i.oldPhysDest;
  end

  always_comb begin
    lsqPkt_o.branchMask = newMask; // Used to squash entries on a mispredict
    lsqPkt_o.isStore    = isStore;
    lsqPkt_o.isLoad     = isLoad;
  end

endmodule

`default_nettype wire

/* rtl/dispatchLatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchLatch (
  input  wire                               clk,
  input  wire                               reset_i,
  input  wire                               stall_i,
  input  wire                               dispatchFire_i,
  input  wire dispatchPkg::dispatchBundle_t bundle_i,
  output dispatchPkg::dispatchBundle_t      bundle_o,
  output logic                              dispatchValid_o
);

  // Valid is the only control state here
  always_ff @(posedge clk) begin
    if (reset_i) begin
      dispatchValid_o <= 1'b0;
    end else if (!stall_i) begin
      dispatchValid_o <= dispatchFire_i; // Drops on recovery or lack of space
    end
  end

  // Payload is don't-care while valid is low
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      bundle_o <= bundle_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/dispatchPkg.sv */
`default_nettype none

package dispatchPkg;

  localparam int DISPATCH_WIDTH    = 4;
  localparam int CHECKPOINTS       = 4;
  localparam int CHECKPOINTS_LOG   = 2;
  localparam int SIZE_PHYSICAL_LOG = 6;
  localparam int SIZE_RMT_LOG      = 5;
  localparam int SIZE_PC           = 32;

  localparam int SIZE_LSQ        = 16; // Each of load and store queue
  localparam int SIZE_ISSUEQ     = 32;
  localparam int SIZE_ACTIVELIST = 64;

  // Occupancy counts must also hold the full value
  localparam int LSQ_CNT_W    = $clog2(SIZE_LSQ) + 1;
  localparam int ISSUEQ_CNT_W = $clog2(SIZE_ISSUEQ) + 1;
  localparam int AL_CNT_W     = $clog2(SIZE_ACTIVELIST) + 1;
  localparam int GRP_CNT_W    = $clog2(DISPATCH_WIDTH) + 1; // Loads or stores in one group

  typedef enum logic [1:0] {
    INST_ALU,
    INST_LOAD,
    INST_STORE,
    INST_BRANCH
  } instType_e;

  typedef logic [CHECKPOINTS-1:0] branchMask_t; // Set bit means dependent on that branch

  typedef struct packed {
    logic [SIZE_PC-1:0]           pc;
    instType_e                    instType;
    logic [CHECKPOINTS_LOG-1:0]   checkpointId;
    branchMask_t                  branchMask;
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic [SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhysDest;
    logic [SIZE_PHYSICAL_LOG-1:0] physSrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] physSrc2;
  } renamedPkt_t;

  typedef struct packed {
    logic [SIZE_PC-1:0]           pc;
    instType_e                    instType;
    logic [CHECKPOINTS_LOG-1:0]   checkpointId;
    branchMask_t                  branchMask;
    logic [SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [SIZE_PHYSICAL_LOG-1:0] physSrc1;
    logic [SIZE_PHYSICAL_LOG-1:0] physSrc2;
    logic                         isLoad;
    logic                         isStore;
  } issuePkt_t;

  typedef struct packed {
    logic                         isLoad;
    logic                         isStore;
    logic [SIZE_PC-1:0]           pc;
    logic [SIZE_RMT_LOG-1:0]      logDest;
    logic [SIZE_PHYSICAL_LOG-1:0] physDest;
    logic [SIZE_PHYSICAL_LOG-1:0] oldPhysDest; // Freed when this instruction retires
  } alPkt_t;

  typedef struct packed {
    branchMask_t branchMask;
    logic        isStore;
    logic        isLoad;
  } lsqPkt_t;

  // Lane 0 sits in the lowest element of each array
  typedef struct packed {
    issuePkt_t [DISPATCH_WIDTH-1:0] issue;
    alPkt_t    [DISPATCH_WIDTH-1:0] al;
    lsqPkt_t   [DISPATCH_WIDTH-1:0] lsq;
  } dispatchBundle_t;

endpackage

`default_nettype wire

/* rtl/dispatchTop.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchTop (
  input  wire                                    clk,
  input  wire                                    reset_i,
  input  wire                                    stall_i,
  input  wire                                    renameReady_i,
  input  wire                                    flagRecoverEX_i,
  input  wire                                    ctrlVerified_i,
  input  wire [dispatchPkg::CHECKPOINTS_LOG-1:0] ctrlVerifiedId_i,
  input  wire dispatchPkg::renamedPkt_t [dispatchPkg::DISPATCH_WIDTH-1:0] renamedPacket_i,
  input  wire [dispatchPkg::LSQ_CNT_W-1:0]       loadQueueCnt_i,
  input  wire [dispatchPkg::LSQ_CNT_W-1:0]       storeQueueCnt_i,
  input  wire [dispatchPkg::ISSUEQ_CNT_W-1:0]    issueQueueCnt_i,
  input  wire [dispatchPkg::AL_CNT_W-1:0]        activeListCnt_i,
  output dispatchPkg::dispatchBundle_t           bundle_o,
  output logic                                   dispatchValid_o,
  output dispatchPkg::branchMask_t [dispatchPkg::DISPATCH_WIDTH-1:0] updatedBranchMask_o,
  output logic                                   backEndReady_o,
  output logic                                   stallFrontEnd_o
);

  dispatchPkg::issuePkt_t [dispatchPkg::DISPATCH_WIDTH-1:0] issuePkt;
  dispatchPkg::alPkt_t    [dispatchPkg::DISPATCH_WIDTH-1:0] alPkt;
  dispatchPkg::lsqPkt_t   [dispatchPkg::DISPATCH_WIDTH-1:0] lsqPkt;
  dispatchPkg::dispatchBundle_t                             bundleNext;
  logic [dispatchPkg::DISPATCH_WIDTH-1:0]                   laneLoad;
  logic [dispatchPkg::DISPATCH_WIDTH-1:0]                   laneStore;

  for (genvar g = 0; g < dispatchPkg::DISPATCH_WIDTH; g++) begin : genLane
    dispatchLane lane (
      .renamedPkt_i     (renamedPacket_i[g]),
      .ctrlVerified_i   (ctrlVerified_i),
      .ctrlVerifiedId_i (ctrlVerifiedId_i),
      .issuePkt_o       (issuePkt[g]),
      .alPkt_o          (alPkt[g]),
      .lsqPkt_o         (lsqPkt[g]),
      .branchMask_o     (updatedBranchMask_o[g])
    );

    assign laneLoad[g]  = issuePkt[g].isLoad;
    assign laneStore[g] = issuePkt[g].isStore;
  end

  assign bundleNext.issue = issuePkt;
  assign bundleNext.al    = alPkt;
  assign bundleNext.lsq   = lsqPkt;

  spaceCheck space0 (
    .isLoad_i        (laneLoad),
    .isStore_i       (laneStore),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .renameReady_i   (renameReady_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .backEndReady_o  (backEndReady_o),
    .stallFrontEnd_o (stallFrontEnd_o)
  );

  // Pipeline register into issue queue, active list and LSQ
  dispatchLatch latch0 (
    .clk             (clk),
    .reset_i         (reset_i),
    .stall_i         (stall_i),
    .dispatchFire_i  (backEndReady_o),
    .bundle_i        (bundleNext),
    .bundle_o        (bundle_o),
    .dispatchValid_o (dispatchValid_o)
  );

endmodule

`default_nettype wire

/* rtl/spaceCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module spaceCheck (
  input  wire [dispatchPkg::DISPATCH_WIDTH-1:0] isLoad_i,
  input  wire [dispatchPkg::DISPATCH_WIDTH-1:0] isStore_i,
  input  wire [dispatchPkg::LSQ_CNT_W-1:0]      loadQueueCnt_i,
  input  wire [dispatchPkg::LSQ_CNT_W-1:0]      storeQueueCnt_i,
  input  wire [dispatchPkg::ISSUEQ_CNT_W-1:0]   issueQueueCnt_i,
  input  wire [dispatchPkg::AL_CNT_W-1:0]       activeListCnt_i,
  input  wire                                   renameReady_i,
  input  wire                                   flagRecoverEX_i,
  output logic                                  backEndReady_o,
  output logic                                  stallFrontEnd_o
);

  logic [dispatchPkg::GRP_CNT_W-1:0]  loadCnt;
  logic [dispatchPkg::GRP_CNT_W-1:0]  storeCnt;
  logic [dispatchPkg::LSQ_CNT_W:0]    loadSum; // One extra bit so the sum cannot wrap
  logic [dispatchPkg::LSQ_CNT_W:0]    storeSum;
  logic [dispatchPkg::ISSUEQ_CNT_W:0] issueSum;
  logic [dispatchPkg::AL_CNT_W:0]     alSum;
  logic                               noSpace;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < dispatchPkg::DISPATCH_WIDTH; i++) begin
      loadCnt  = loadCnt + (dispatchPkg::GRP_CNT_W)'(isLoad_i[i]);
      storeCnt = storeCnt + (dispatchPkg::GRP_CNT_W)'(isStore_i[i]);
    end
  end

  assign loadSum  = {1'b0, loadQueueCnt_i} + (dispatchPkg::LSQ_CNT_W + 1)'(loadCnt);
  assign storeSum = {1'b0, storeQueueCnt_i} + (dispatchPkg::LSQ_CNT_W + 1)'(storeCnt);

  // Issue queue and active list take a whole group regardless of type
  assign issueSum = {1'b0, issueQueueCnt_i}
                  + (dispatchPkg::ISSUEQ_CNT_W + 1)'(dispatchPkg::DISPATCH_WIDTH);
  assign alSum    = {1'b0, activeListCnt_i}
                  + (dispatchPkg::AL_CNT_W + 1)'(dispatchPkg::DISPATCH_WIDTH);

  assign noSpace = (loadSum  > (dispatchPkg::LSQ_CNT_W + 1)'(dispatchPkg::SIZE_LSQ))
                 | (storeSum > (dispatchPkg::LSQ_CNT_W + 1)'(dispatchPkg::SIZE_LSQ))
                 | (issueSum > (dispatchPkg::ISSUEQ_CNT_W + 1)'(dispatchPkg::SIZE_ISSUEQ))
                 | (alSum    > (dispatchPkg::AL_CNT_W + 1)'(dispatchPkg::SIZE_ACTIVELIST));

  assign stallFrontEnd_o = noSpace; // Hold decode and rename
  assign backEndReady_o  = ~noSpace & renameReady_i & ~flagRecoverEX_i;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the dispatch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module dispatchTb -f all.f -o simDispatch

# The log decides pass or fail, so the pipe status is not used
./obj_dir/simDispatch 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* test/dispatchTb.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchTb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_ROWS     = 25;
  localparam int W            = dispatchPkg::DISPATCH_WIDTH;

  // Types and masks hold lane 0 in their low bits
  typedef struct packed {
    logic [7:0]                             types; // 0 ALU, 1 load, 2 store, 3 branch
    logic [15:0]                            masks;
    logic                                   verified;
    logic [dispatchPkg::CHECKPOINTS_LOG-1:0] verifiedId;
    logic [dispatchPkg::LSQ_CNT_W-1:0]      ldCnt;
    logic [dispatchPkg::LSQ_CNT_W-1:0]      stCnt;
    logic [dispatchPkg::ISSUEQ_CNT_W-1:0]   iqCnt;
    logic [dispatchPkg::AL_CNT_W-1:0]       alCnt;
    logic                                   renameReady;
    logic                                   recover;
    logic                                   stall;
    logic                                   expReady;
    logic                                   expStallFe;
  } stimRow_t;

  logic                                    clk;
  logic                                    reset_i;
  logic                                    stall_i;
  logic                                    renameReady_i;
  logic                                    flagRecoverEX_i;
  logic                                    ctrlVerified_i;
  logic [dispatchPkg::CHECKPOINTS_LOG-1:0] ctrlVerifiedId_i;
  dispatchPkg::renamedPkt_t [W-1:0]        renamedPacket_i;
  logic [dispatchPkg::LSQ_CNT_W-1:0]       loadQueueCnt_i;
  logic [dispatchPkg::LSQ_CNT_W-1:0]       storeQueueCnt_i;
  logic [dispatchPkg::ISSUEQ_CNT_W-1:0]    issueQueueCnt_i;
  logic [dispatchPkg::AL_CNT_W-1:0]        activeListCnt_i;
  dispatchPkg::dispatchBundle_t            bundle_o;
  logic                                    dispatchValid_o;
  dispatchPkg::branchMask_t [W-1:0]        updatedBranchMask_o;
  logic                                    backEndReady_o;
  logic                                    stallFrontEnd_o;

  stimRow_t                         rows [NUM_ROWS];
  int                               rowCount;
  int                               errors;
  int                               checks;
  integer                           seed;
  dispatchPkg::dispatchBundle_t     expNext;    // Packets of the row now on the inputs
  dispatchPkg::dispatchBundle_t     expLatched; // What the pipeline register should hold
  dispatchPkg::branchMask_t [W-1:0] expMask;
  logic                             expValid;

  dispatchTop dut0 (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic addRow(input logic [7:0] types, input logic [15:0] masks, input int ver,
                        input int vid, input int ld, input int st, input int iq, input int al,
                        input int rr, input int rec, input int stall, input int expReady,
                        input int expStallFe);
    stimRow_t r;
    r.types       = types;
    r.masks       = masks;
    r.verified    = (ver != 0);
    r.verifiedId  = (dispatchPkg::CHECKPOINTS_LOG)'(vid);
    r.ldCnt       = (dispatchPkg::LSQ_CNT_W)'(ld);
    r.stCnt       = (dispatchPkg::LSQ_CNT_W)'(st);
    r.iqCnt       = (dispatchPkg::ISSUEQ_CNT_W)'(iq);
    r.alCnt       = (dispatchPkg::AL_CNT_W)'(al);
    r.renameReady = (rr != 0);
    r.recover     = (rec != 0);
    r.stall       = (stall != 0);
    r.expReady    = (expReady != 0);
    r.expStallFe  = (expStallFe != 0);
    rows[rowCount] = r;
    rowCount++;
  endtask

  task automatic buildTable();
    //     types        masks     ver vid ld  st  iq  al  rr rec stl rdy stf
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  0,  0,  0, 0, 0, 0, 0);
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  0,  0,  1, 0, 0, 1, 0);
    addRow(8'b11_10_01_00, 16'hF5A3, 0, 0, 3,  2,  10, 20, 1, 0, 0, 1, 0);
    addRow(8'b11_10_01_00, 16'hFFFF, 1, 2, 3,  2,  10, 20, 1, 0, 0, 1, 0);
    addRow(8'b01_10_11_00, 16'h7C4F, 1, 0, 0,  0,  0,  0,  1, 0, 0, 1, 0);
    addRow(8'b10_01_00_11, 16'h8888, 1, 3, 0,  0,  0,  0,  1, 0, 0, 1, 0);
    addRow(8'b01_01_01_01, 16'h1234, 1, 1, 12, 0,  0,  0,  1, 0, 0, 1, 0); // LQ exactly full
    addRow(8'b01_01_01_01, 16'h0000, 0, 0, 13, 0,  0,  0,  1, 0, 0, 0, 1);
    addRow(8'b10_10_10_10, 16'h0000, 0, 0, 0,  12, 0,  0,  1, 0, 0, 1, 0);
    addRow(8'b10_10_10_10, 16'h0000, 0, 0, 0,  13, 0,  0,  1, 0, 0, 0, 1);
    addRow(8'b10_10_10_10, 16'h0000, 0, 0, 16, 0,  0,  0,  1, 0, 0, 1, 0); // Full LQ, no loads
    addRow(8'b00_00_01_00, 16'h0000, 0, 0, 15, 0,  0,  0,  1, 0, 0, 1, 0);
    addRow(8'b01_00_01_00, 16'h0000, 0, 0, 15, 0,  0,  0,  1, 0, 0, 0, 1);
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  28, 0,  1, 0, 0, 1, 0);
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  29, 0,  1, 0, 0, 0, 1);
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  0,  60, 1, 0, 0, 1, 0);
    addRow(8'b00_00_00_00, 16'h0000, 0, 0, 0,  0,  0,  61, 1, 0, 0, 0, 1);
    addRow(8'b11_00_01_10, 16'h3C21, 0, 0, 4,  4,  8,  8,  0, 0, 0, 0, 0);
    addRow(8'b11_00_01_10, 16'h3C21, 0, 0, 4,  4,  8,  8,  1, 1, 0, 0, 0);
    addRow(8'b10_01_11_00, 16'hA5C3, 1, 1, 4,  4,  8,  8,  1, 0, 0, 1, 0);
    addRow(8'b01_11_10_00, 16'h0F0F, 0, 0, 2,  2,  2,  2,  1, 0, 1, 1, 0); // Holds previous group
    addRow(8'b00_01_00_10, 16'hFFFF, 1, 3, 2,  2,  2,  2,  1, 1, 1, 0, 0); // Recovery under stall
    addRow(8'b00_01_00_10, 16'hFFFF, 1, 3, 2,  2,  2,  2,  1, 1, 0, 0, 0);
    addRow(8'b10_01_10_01, 16'h6E17, 1, 2, 4,  4,  8,  8,  1, 0, 0, 1, 0);
    addRow(8'b01_01_01_01, 16'h0000, 0, 0, 14, 0,  0,  64, 1, 0, 1, 0, 1);
  endtask

  // Verified checkpoint no longer guards anything
  function automatic dispatchPkg::branchMask_t clearVerified(
      input dispatchPkg::branchMask_t mask, input logic verified,
      input logic [dispatchPkg::CHECKPOINTS_LOG-1:0] id);
    dispatchPkg::branchMask_t result;
    result = mask;
    for (int b = 0; b < dispatchPkg::CHECKPOINTS; b++) begin
      if (verified && int'(id) == b) begin
        result[b] = 1'b0;
      end
    end
    return result;
  endfunction

  task automatic driveRow(input stimRow_t r);
    dispatchPkg::renamedPkt_t [W-1:0] pkts;
    dispatchPkg::branchMask_t         mask;
    logic                             ld;
    logic                             st;
    for (int l = 0; l < W; l++) begin
      pkts[l].pc           = $random(seed);
      pkts[l].instType     = dispatchPkg::instType_e'(r.types[2*l +: 2]);
      pkts[l].checkpointId = (dispatchPkg::CHECKPOINTS_LOG)'($random(seed));
      pkts[l].branchMask   = r.masks[4*l +: 4];
      pkts[l].logDest      = (dispatchPkg::SIZE_RMT_LOG)'($random(seed));
      pkts[l].physDest     = (dispatchPkg::SIZE_PHYSICAL_LOG)'($random(seed));
      pkts[l].oldPhysDest  = (dispatchPkg::SIZE_PHYSICAL_LOG)'($random(seed));
      pkts[l].physSrc1     = (dispatchPkg::SIZE_PHYSICAL_LOG)'($random(seed));
      pkts[l].physSrc2     = (dispatchPkg::SIZE_PHYSICAL_LOG)'($random(seed));
      mask = clearVerified(pkts[l].branchMask, r.verified, r.verifiedId);
      ld   = (r.types[2*l +: 2] == 2'd1);
      st   = (r.types[2*l +: 2] == 2'd2);
      expMask[l]                    = mask;
      expNext.issue[l].pc           = pkts[l].pc;
      expNext.issue[l].instType     = pkts[l].instType;
      expNext.issue[l].checkpointId = pkts[l].checkpointId;
      expNext.issue[l].branchMask   = mask;
      expNext.issue[l].physDest     = pkts[l].physDest;
      expNext.issue[l].physSrc1     = pkts[l].physSrc1;
      expNext.issue[l].physSrc2     = pkts[l].physSrc2;
      expNext.issue[l].isLoad       = ld;
      expNext.issue[l].isStore      = st;
      expNext.al[l].isLoad          = ld;
      expNext.al[l].isStore         = st;
      expNext.al[l].pc              = pkts[l].pc;
      expNext.al[l].logDest         = pkts[l].logDest;
      expNext.al[l].physDest        = pkts[l].physDest;
      expNext.al[l].oldPhysDest     = pkts[l].oldPhysDest;
      expNext.lsq[l].branchMask     = mask;
      expNext.lsq[l].isStore        = st;
      expNext.lsq[l].isLoad         = ld;
    end
    renamedPacket_i  <= pkts;
    ctrlVerified_i   <= r.verified;
    ctrlVerifiedId_i <= r.verifiedId;
    loadQueueCnt_i   <= r.ldCnt;
    storeQueueCnt_i  <= r.stCnt;
    issueQueueCnt_i  <= r.iqCnt;
    activeListCnt_i  <= r.alCnt;
    renameReady_i    <= r.renameReady;
    flagRecoverEX_i  <= r.recover;
    stall_i          <= r.stall;
  endtask

  task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkComb(input stimRow_t r);
    checkVal("backEndReady_o", 64'(backEndReady_o), 64'(r.expReady));
    checkVal("stallFrontEnd_o", 64'(stallFrontEnd_o), 64'(r.expStallFe));
    for (int l = 0; l < W; l++) begin
      checkVal($sformatf("updatedBranchMask_o[%0d]", l), 64'(updatedBranchMask_o[l]),
               64'(expMask[l]));
    end
  endtask

  task automatic checkLatched();
    checkVal("dispatchValid_o", 64'(dispatchValid_o), 64'(expValid));
    if (expValid) begin // Payload only matters with valid high
      for (int l = 0; l < W; l++) begin
        checkVal($sformatf("bundle_o.issue[%0d]", l), 64'(bundle_o.issue[l]),
                 64'(expLatched.issue[l]));
        checkVal($sformatf("bundle_o.al[%0d]", l), 64'(bundle_o.al[l]), 64'(expLatched.al[l]));
        checkVal($sformatf("bundle_o.lsq[%0d]", l), 64'(bundle_o.lsq[l]),
                 64'(expLatched.lsq[l]));
      end
    end
  endtask

  initial begin
    #((NUM_ROWS + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the test sequence did not finish in the expected time");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    seed             = 32'h9788_caaa;
    errors           = 0;
    checks           = 0;
    rowCount         = 0;
    expValid         = 1'b0;
    expNext          = '0;
    expLatched       = '0;
    expMask          = '0;
    clk              = 1'b0;
    reset_i          = 1'b1;
    stall_i          = 1'b0;
    renameReady_i    = 1'b0;
    flagRecoverEX_i  = 1'b0;
    ctrlVerified_i   = 1'b0;
    ctrlVerifiedId_i = '0;
    renamedPacket_i  = '0;
    loadQueueCnt_i   = '0;
    storeQueueCnt_i  = '0;
    issueQueueCnt_i  = '0;
    activeListCnt_i  = '0;
    buildTable();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    driveRow(rows[0]);
    for (int k = 0; k < NUM_ROWS; k++) begin
      @(negedge clk); // Combinational outputs settled, register updated
      checkComb(rows[k]);
      checkLatched();
      @(posedge clk);
      if (!rows[k].stall) begin
        expValid   = rows[k].expReady;
        expLatched = expNext;
      end
      if (k + 1 < NUM_ROWS) begin
        driveRow(rows[k + 1]);
      end
    end
    @(negedge clk);
    checkLatched();
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut0.assert0.failCount);
    if (errors == 0 && dut0.assert0.failCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/dispatch_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatchAssert (
  input wire clk,
  input wire reset_i,
  input wire stall_i,
  input wire backEndReady_i,
  input wire stallFrontEnd_i,
  input wire dispatchValid_i
);

  int failCount = 0;

  // Ready needs room in every back-end structure
  readyNotStalled: assert property (
    @(posedge clk) disable iff (reset_i) backEndReady_i |-> !stallFrontEnd_i
  ) else begin
    failCount++;
    $error("backEndReady_o and stallFrontEnd_o both high");
  end

  validClearedByReset: assert property (
    @(posedge clk) reset_i |=> !dispatchValid_i
  ) else begin
    failCount++;
    $error("dispatchValid_o not low in the cycle after reset");
  end

  validHeldInStall: assert property (
    @(posedge clk) disable iff (reset_i) stall_i |=> $stable(dispatchValid_i)
  ) else begin
    failCount++;
    $error("dispatchValid_o changed across a stalled edge");
  end

endmodule

bind dispatchTop dispatchAssert assert0 (
  .clk             (clk),
  .reset_i         (reset_i),
  .stall_i         (stall_i),
  .backEndReady_i  (backEndReady_o),
  .stallFrontEnd_i (stallFrontEnd_o),
  .dispatchValid_i (dispatchValid_o)
);

`default_nettype wire
